// File: verilog/tm_qm_types_pkg.sv
package tm_qm_types_pkg;

	// Queue id width, 16 first-level queues by default.
	parameter int QID_W = 4;

	// Number of queues addressed by a qid_t.
	parameter int NUM_QUEUES = 1 << QID_W;

	// A queue id as carried by the enqueue and dequeue requests.
	typedef logic [QID_W-1:0] qid_t;

	// Depth of one queue.
	// It has the same width as the id, so a queue holds at most 2^QID_W - 1 entries.
	typedef logic [QID_W-1:0] depth_t;

	// Largest depth a queue can reach.
	parameter depth_t DEPTH_MAX = '1;

endpackage

// File: verilog/tm_qm_msg_pkg.sv
package tm_qm_msg_pkg;

	import tm_qm_types_pkg::*;

	// Request from the egress processor (enqueue) or the scheduler (dequeue).
	typedef struct packed {
		logic req; // Single-cycle pulse.
		qid_t qid; // Queue the request targets.
	} enq_cmd_t;

	// Response to one request.
	typedef struct packed {
		logic ack;  // Single-cycle pulse.
		logic flag; // Valid with ack only.
	} qm_resp_t;

	// RAM initialisation sequence after reset.
	typedef enum logic [1:0] {
		INIT_IDLE  = 2'd0,
		INIT_CLEAR = 2'd1,
		INIT_DONE  = 2'd2
	} init_state_e;

endpackage

// File: verilog/tm_qm_init_ctrl.sv
`timescale 1ns/1ps

module tm_qm_init_ctrl
	import tm_qm_types_pkg::*;
	import tm_qm_msg_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	output logic init_wr,
	output qid_t init_addr,
	output logic ready
);

	init_state_e state;
	init_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			INIT_IDLE: state_nxt = INIT_CLEAR;
			INIT_CLEAR: begin
				if (&init_addr) // Last address is written in this cycle.
					state_nxt = INIT_DONE;
			end
			INIT_DONE: state_nxt = INIT_DONE;
			default: state_nxt = INIT_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= INIT_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Sweep address, one entry per cycle while clearing.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			init_addr <= '0;
		end else if (init_wr) begin
			init_addr <= init_addr + 1'b1; // Wraps back to zero after the last entry.
		end
	end

	assign init_wr = (state == INIT_CLEAR);
	assign ready   = (state == INIT_DONE); // Stays high until the next reset.

endmodule

// File: verilog/tm_qm_enq_fifo.sv
`timescale 1ns/1ps

module tm_qm_enq_fifo
	import tm_qm_types_pkg::*;
#(
	parameter int QID_W          = tm_qm_types_pkg::QID_W,
	parameter int ENQ_FIFO_DEPTH = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic wr,
	input  qid_t din,
	input  logic rd,
	output qid_t dout,
	output logic empty
);

	localparam int PTR_W = (ENQ_FIFO_DEPTH > 1) ? $clog2(ENQ_FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(ENQ_FIFO_DEPTH + 1);

	logic [QID_W-1:0] mem [ENQ_FIFO_DEPTH];

	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             push;
	logic             pop;

	assign full  = (count == CNT_W'(ENQ_FIFO_DEPTH));
	assign empty = (count == '0);
	assign push  = wr & ~full;
	assign pop   = rd & ~empty;

	// Head entry falls through to the output.
	assign dout = mem[rptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wptr] <= din;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (push)
				wptr <= (wptr == PTR_W'(ENQ_FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (pop)
				rptr <= (rptr == PTR_W'(ENQ_FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
			// Simultaneous push and pop leave the count as it is.
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: verilog/tm_qm_depth_ram.sv
`timescale 1ns/1ps

module tm_qm_depth_ram
	import tm_qm_types_pkg::*;
#(
	parameter int QID_W = tm_qm_types_pkg::QID_W
) (
	input  logic   clk,
	input  logic   wr,
	input  qid_t   waddr,
	input  qid_t   raddr,
	input  depth_t din,
	output depth_t dout
);

	// One depth per queue, cleared by the init sweep.
	depth_t mem [1 << QID_W];

	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= din;
	end

	// Registered read, old data on a same-address write.
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

// File: verilog/tm_qm_depth.sv
`timescale 1ns/1ps

module tm_qm_depth
	import tm_qm_types_pkg::*;
	import tm_qm_msg_pkg::*;
#(
	parameter int QID_W = tm_qm_types_pkg::QID_W
) (
	input  logic     clk,
	input  logic     rst_n,

	input  enq_cmd_t enq,
	input  enq_cmd_t deq,

	input  logic     init_wr,
	input  qid_t     init_addr,

	output qm_resp_t enq_resp,
	output qm_resp_t deq_resp,

	output logic     fifo_wr,
	output qid_t     fifo_din,
	output logic     fifo_rd,
	input  logic     fifo_empty,
	input  qid_t     fifo_dout,

	output logic     ram_wr,
	output qid_t     ram_waddr,
	output qid_t     ram_raddr,
	output depth_t   ram_wdata,
	input  depth_t   ram_dout
);

	// Stage 1 holds the registered requests and drives the RAM read address.
	enq_cmd_t enq_d1;
	enq_cmd_t deq_d1;

	// Stage 2 sees the RAM data and computes the new depth.
	logic     deq_d2;
	logic     rd_d1;
	qid_t     raddr_d1;
	logic     stage2_vld;
	depth_t   old_depth;
	depth_t   new_depth;

	// Write stage and the write before it, both usable for forwarding.
	logic     wr_q;
	qid_t     waddr_q;
	depth_t   wdata_q;
	depth_t   wdata_q2;
	logic [1:0] fwd_sel; // Bit 0 selects wdata_q, bit 1 wdata_q2.

	logic     enq_ack;
	logic     enq_flag;
	logic     deq_ack;
	logic     deq_flag;

	// Enqueues go through the latency FIFO.
	assign fifo_wr  = enq_d1.req;
	assign fifo_din = enq_d1.qid;

	// The FIFO head only gets the read port when stage 1 has no dequeue.
	assign fifo_rd   = ~deq_d1.req & ~fifo_empty;
	assign ram_raddr = deq_d1.req ? deq_d1.qid : fifo_dout;

	assign stage2_vld = deq_d2 | rd_d1;

	// Newest in-flight write first, then the one reaching the RAM this cycle.
	always_comb begin
		if (fwd_sel[0])
			old_depth = wdata_q;
		else if (fwd_sel[1])
			old_depth = wdata_q2;
		else
			old_depth = ram_dout;
	end

	assign new_depth = deq_d2 ? depth_t'(old_depth - 1'b1) : depth_t'(old_depth + 1'b1);

	// Sweep writes take the port while the RAM is being cleared.
	assign ram_wr    = init_wr | wr_q;
	assign ram_waddr = init_wr ? init_addr : waddr_q;
	assign ram_wdata = init_wr ? {QID_W{1'b0}} : wdata_q;

	assign enq_resp = '{ack: enq_ack, flag: enq_flag};
	assign deq_resp = '{ack: deq_ack, flag: deq_flag};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enq_d1  <= '0;
			deq_d1  <= '0;
			deq_d2  <= 1'b0;
			rd_d1   <= 1'b0;
			wr_q    <= 1'b0;
			enq_ack <= 1'b0;
			deq_ack <= 1'b0;
		end else begin
			enq_d1  <= enq;
			deq_d1  <= deq;
			deq_d2  <= deq_d1.req;
			rd_d1   <= fifo_rd;
			wr_q    <= stage2_vld; // Every event writes back its new depth.
			enq_ack <= rd_d1;
			deq_ack <= deq_d2;
		end
	end

	always_ff @(posedge clk) begin
		raddr_d1 <= ram_raddr;
		waddr_q  <= raddr_d1;
		wdata_q  <= new_depth;
		wdata_q2 <= wdata_q;

		// The stage 2 event is written one cycle after the read that follows it.
		fwd_sel[0] <= stage2_vld & (raddr_d1 == ram_raddr);
		// A write on the same edge as the read is not seen by the RAM output.
		fwd_sel[1] <= wr_q & (waddr_q == ram_raddr);

		enq_flag <= (old_depth == '0);         // Queue was empty.
		deq_flag <= (old_depth > depth_t'(1)); // Queue keeps an entry after this one.
	end

endmodule

// File: verilog/tm_qm_top.sv
`timescale 1ns/1ps

module tm_qm_top
	import tm_qm_types_pkg::*;
	import tm_qm_msg_pkg::*;
#(
	parameter int QID_W          = tm_qm_types_pkg::QID_W,
	parameter int ENQ_FIFO_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  enq_cmd_t enq,
	input  enq_cmd_t deq,
	output qm_resp_t enq_resp,
	output qm_resp_t deq_resp,
	output logic     ready
);

	logic   init_wr;
	qid_t   init_addr;

	logic   fifo_wr;
	logic   fifo_rd;
	logic   fifo_empty;
	qid_t   fifo_din;
	qid_t   fifo_dout;

	logic   ram_wr;
	qid_t   ram_waddr;
	qid_t   ram_raddr;
	depth_t ram_wdata;
	depth_t ram_dout;

	tm_qm_init_ctrl u_init_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.init_wr   (init_wr),
		.init_addr (init_addr),
		.ready     (ready)
	);

	tm_qm_enq_fifo #(
		.QID_W          (QID_W),
		.ENQ_FIFO_DEPTH (ENQ_FIFO_DEPTH)
	) u_enq_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (fifo_wr),
		.din   (fifo_din),
		.rd    (fifo_rd),
		.dout  (fifo_dout),
		.empty (fifo_empty)
	);

	tm_qm_depth_ram #(
		.QID_W (QID_W)
	) u_depth_ram (
		.clk   (clk),
		.wr    (ram_wr),
		.waddr (ram_waddr),
		.raddr (ram_raddr),
		.din   (ram_wdata),
		.dout  (ram_dout)
	);

	tm_qm_depth #(
		.QID_W (QID_W)
	) u_depth (
		.clk        (clk),
		.rst_n      (rst_n),
		.enq        (enq),
		.deq        (deq),
		.init_wr    (init_wr),
		.init_addr  (init_addr),
		.enq_resp   (enq_resp),
		.deq_resp   (deq_resp),
		.fifo_wr    (fifo_wr),
		.fifo_din   (fifo_din),
		.fifo_rd    (fifo_rd),
		.fifo_empty (fifo_empty),
		.fifo_dout  (fifo_dout),
		.ram_wr     (ram_wr),
		.ram_waddr  (ram_waddr),
		.ram_raddr  (ram_raddr),
		.ram_wdata  (ram_wdata),
		.ram_dout   (ram_dout)
	);

endmodule

// File: sim/tm_qm_assert.sv
`timescale 1ns/1ps

module tm_qm_assert
	import tm_qm_types_pkg::*;
	import tm_qm_msg_pkg::*;
#(
	parameter int QID_W          = tm_qm_types_pkg::QID_W,
	parameter int ENQ_FIFO_DEPTH = 4
) (
	input logic     clk,
	input logic     rst_n,
	input enq_cmd_t enq,
	input enq_cmd_t deq,
	input qm_resp_t enq_resp,
	input qm_resp_t deq_resp,
	input logic     init_wr,
	input qid_t     init_addr,
	input qid_t     waddr_q
);

	int   fail_count = 0;
	logic ready_m; // High from the cycle after the last sweep write.
	int   out_cnt; // Enqueues not yet acknowledged.
	int   depth [1 << QID_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_m <= 1'b0;
			out_cnt <= 0;
			for (int i = 0; i < (1 << QID_W); i++)
				depth[i] <= 0;
		end else begin
			if (init_wr && &init_addr)
				ready_m <= 1'b1;
			out_cnt <= out_cnt + int'(enq.req) - int'(enq_resp.ack);
			// The write address is the acknowledged event's queue.
			if (enq_resp.ack)
				depth[waddr_q] <= depth[waddr_q] + 1;
			if (deq_resp.ack)
				depth[waddr_q] <= depth[waddr_q] - 1;
		end
	end

	a_req_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(enq.req || deq.req) |-> ready_m)
		else begin $error("Request before ready"); fail_count++; end

	a_ack_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!ready_m |-> !(enq_resp.ack || deq_resp.ack))
		else begin $error("Acknowledge before ready"); fail_count++; end

	a_deq_lat: assert property (@(posedge clk) disable iff (!rst_n)
		deq.req |-> ##3 deq_resp.ack)
		else begin $error("Dequeue acknowledge late or missing"); fail_count++; end

	a_deq_src: assert property (@(posedge clk) disable iff (!rst_n)
		deq_resp.ack |-> $past(deq.req, 3))
		else begin $error("Dequeue acknowledge without request"); fail_count++; end

	a_enq_limit: assert property (@(posedge clk) disable iff (!rst_n)
		enq.req |-> out_cnt < ENQ_FIFO_DEPTH)
		else begin $error("Too many enqueues outstanding"); fail_count++; end

	a_deq_empty: assert property (@(posedge clk) disable iff (!rst_n)
		deq.req |-> depth[deq.qid] != 0)
		else begin $error("Dequeue on an empty queue"); fail_count++; end

	a_enq_full: assert property (@(posedge clk) disable iff (!rst_n)
		enq.req |-> depth[enq.qid] != (1 << QID_W) - 1)
		else begin $error("Enqueue on a full queue"); fail_count++; end

endmodule

bind tm_qm_depth tm_qm_assert #(
	.QID_W (QID_W)
) u_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.enq       (enq),
	.deq       (deq),
	.enq_resp  (enq_resp),
	.deq_resp  (deq_resp),
	.init_wr   (init_wr),
	.init_addr (init_addr),
	.waddr_q   (waddr_q)
);

// File: sim/tm_qm_tb.sv
`timescale 1ns/1ps

module tm_qm_tb
	import tm_qm_types_pkg::*;
	import tm_qm_msg_pkg::*;
();

	localparam int NQ     = 16;
	localparam int FIFO_D = 4;
	localparam int MAXD   = NQ - 1; // Depth is as wide as the id.

	logic     clk = 1'b0;
	logic     rst_n;
	enq_cmd_t enq;
	enq_cmd_t deq;
	qm_resp_t enq_resp;
	qm_resp_t deq_resp;
	logic     ready;

	int    errors;
	string test_name;

	// Issue-side counts belong to the stimulus, ack-side counts to the monitor.
	int iss_enq_cnt [NQ];
	int iss_deq_cnt [NQ];
	int ack_enq_cnt [NQ];
	int ref_depth   [NQ];
	int iss_enq;
	int iss_deq;
	int ack_enq;
	int ack_deq;
	int enq_ids [$]; // Enqueues are acknowledged in issue order.
	int deq_ids [$];

	always #2 clk = ~clk;

	tm_qm_top #(
		.QID_W          (4),
		.ENQ_FIFO_DEPTH (FIFO_D)
	) UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.enq      (enq),
		.deq      (deq),
		.enq_resp (enq_resp),
		.deq_resp (deq_resp),
		.ready    (ready)
	);

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error %s %s: expected %0b, actual %0b", test_name, what, exp, act);
			errors++;
		end
	endtask

	// Reference depth model, updated at each acknowledge.
	always @(negedge clk) begin
		int q;
		if (rst_n) begin
			if (enq_resp.ack) begin
				if (enq_ids.size() == 0) begin
					$display("Enqueue acknowledge with no enqueue outstanding in %s", test_name);
					errors++;
				end else begin
					q = enq_ids.pop_front();
					check_flag($sformatf("enq flag q%0d", q), ref_depth[q] == 0, enq_resp.flag);
					ref_depth[q]++;
					ack_enq_cnt[q]++;
					ack_enq++;
				end
			end
			if (deq_resp.ack) begin
				if (deq_ids.size() == 0) begin
					$display("Dequeue acknowledge with no dequeue outstanding in %s", test_name);
					errors++;
				end else begin
					q = deq_ids.pop_front();
					check_flag($sformatf("deq flag q%0d", q), ref_depth[q] > 1, deq_resp.flag);
					ref_depth[q]--;
					ack_deq++;
				end
			end
		end
	end

	// One cycle of stimulus. Requests that would break the requester rules are dropped.
	task automatic step(input logic ev, input int eq, input logic dv, input int dq);
		logic e_ok;
		logic d_ok;
		e_ok = ev && (iss_enq - ack_enq < FIFO_D)
			&& (ref_depth[eq] + iss_enq_cnt[eq] - ack_enq_cnt[eq] < MAXD);
		d_ok = dv && (ack_enq_cnt[dq] - iss_deq_cnt[dq] > 0);
		@(posedge clk);
		enq <= '{req: e_ok, qid: qid_t'(eq)};
		deq <= '{req: d_ok, qid: qid_t'(dq)};
		if (e_ok) begin
			iss_enq++;
			iss_enq_cnt[eq]++;
			enq_ids.push_back(eq);
		end
		if (d_ok) begin
			iss_deq++;
			iss_deq_cnt[dq]++;
			deq_ids.push_back(dq);
		end
	endtask

	task automatic enq_wait(input int q);
		int t;
		for (t = 0; t < 50; t++) begin
			if ((iss_enq - ack_enq < FIFO_D)
				&& (ref_depth[q] + iss_enq_cnt[q] - ack_enq_cnt[q] < MAXD)) begin
				step(1'b1, q, 1'b0, 0);
				return;
			end
			step(1'b0, 0, 1'b0, 0);
		end
		$display("Timeout in %s waiting to enqueue on queue %0d", test_name, q);
		errors++;
	endtask

	task automatic drain();
		int t;
		for (t = 0; t < 200; t++) begin
			if (ack_enq == iss_enq && ack_deq == iss_deq)
				return;
			step(1'b0, 0, 1'b0, 0);
		end
		$display("Timeout in %s waiting for outstanding acknowledges", test_name);
		errors++;
	endtask

	initial begin
		int t;
		int i;
		int base;
		void'($urandom(32'hce7a_52cf));
		errors    = 0;
		test_name = "reset";
		rst_n     = 1'b0;
		enq       = '0;
		deq       = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "init_sweep";
		for (t = 0; t < 40 && !ready; t++)
			@(posedge clk);
		if (!ready) begin
			$display("Timeout waiting for ready after reset");
			errors++;
		end

		test_name = "cleared_queue";
		step(1'b1, 3, 1'b0, 0);
		drain();
		step(1'b1, 3, 1'b0, 0); // Second enqueue sees depth one.
		drain();

		test_name = "back_to_back";
		step(1'b1, 5, 1'b0, 0);
		step(1'b1, 5, 1'b0, 0);
		step(1'b1, 5, 1'b0, 0);
		drain();
		step(1'b0, 0, 1'b1, 5);
		step(1'b0, 0, 1'b1, 5);
		step(1'b1, 5, 1'b0, 0);
		step(1'b1, 5, 1'b0, 0);
		drain();
		step(1'b0, 0, 1'b1, 5);
		step(1'b0, 0, 1'b0, 0); // One-cycle gap uses the older write.
		step(1'b0, 0, 1'b1, 5);
		drain();

		test_name = "deq_burst";
		for (i = 0; i < 12; i++)
			enq_wait(7);
		drain();
		base = ack_enq_cnt[1];
		for (i = 0; i < 10; i++)
			step(i < 4, 1, 1'b1, 7);
		drain();
		if (ack_enq_cnt[1] - base != 4) begin
			$display("** Error %s enqueue acknowledges: expected 4, actual %0d",
				test_name, ack_enq_cnt[1] - base);
			errors++;
		end

		test_name = "random_mix";
		for (i = 0; i < 600; i++)
			step(($urandom % 3) != 0, $urandom % NQ, ($urandom % 2) != 0, $urandom % NQ);
		drain();

		$display("Model errors: %0d, assertion failures: %0d",
			errors, UUT.u_depth.u_assert.fail_count);
		if (errors == 0 && UUT.u_depth.u_assert.fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: filelist.f
verilog/tm_qm_types_pkg.sv
verilog/tm_qm_msg_pkg.sv
verilog/tm_qm_init_ctrl.sv
verilog/tm_qm_enq_fifo.sv
verilog/tm_qm_depth_ram.sv
verilog/tm_qm_depth.sv
verilog/tm_qm_top.sv
sim/tm_qm_assert.sv
sim/tm_qm_tb.sv
